//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  localparam int ADDR_W         = 32;  // address and data word width
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_BITS    = 4;   // byte offset in a 16-byte line

  typedef logic [ADDR_W-1:0] word_t;
  typedef word_t [WORDS_PER_LINE-1:0] line_t;  // word 0 in the low bits

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } req_op_e;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE,
    MISS_DIRTY,
    MISS_CLEAN,
    REFILL
  } cache_state_e;

  typedef struct packed {
    req_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        wstrb;  // data already sits on its byte lanes
    word_t             wdata;
  } cpu_req_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;  // line aligned
  } mem_rd_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;  // line aligned
    line_t             data;
  } mem_wr_t;

  // index and tag sized for 256 sets
  typedef struct packed {
    logic        en;
    logic [7:0]  index;
    logic [19:0] tag;
    line_t       line;
    logic        dirty;
  } way_wr_t;

endpackage

`default_nettype wire

//--- design/way_store.sv
`timescale 1ns/100ps
`default_nettype none

module way_store #(
  parameter int INDEX_BITS = 8,
  localparam int TAG_BITS  = dcache_pkg::ADDR_W - INDEX_BITS - dcache_pkg::OFFSET_BITS
) (
  input  wire                      clk,
  input  wire                      resetn,
  input  wire [INDEX_BITS-1:0]     rd_index,
  input  wire dcache_pkg::way_wr_t wr,
  output logic [TAG_BITS-1:0]      tag,
  output logic                     valid,
  output logic                     dirty,
  output dcache_pkg::line_t        line
);

  localparam int SETS = 1 << INDEX_BITS;

  logic [TAG_BITS-1:0] tag_mem [SETS];
  dcache_pkg::line_t   data_mem [SETS];
  logic [SETS-1:0]     valid_bits;
  logic [SETS-1:0]     dirty_bits;
  logic                wr_same;  // write and read address the same set

  assign wr_same = wr.en && (wr.index == rd_index);

  always_ff @(posedge clk) begin
    if (wr.en) begin
      tag_mem[wr.index]  <= wr.tag;
      data_mem[wr.index] <= wr.line;
    end
  end

  // write-first read port
  // a refilled line is visible to the lookup right after it
  always_ff @(posedge clk) begin
    tag  <= wr_same ? wr.tag : tag_mem[rd_index];
    line <= wr_same ? wr.line : data_mem[rd_index];
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (wr.en) begin
      valid_bits[wr.index] <= 1'b1;
      dirty_bits[wr.index] <= wr.dirty;  // refill clean, store dirty
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid <= 1'b0;
      dirty <= 1'b0;
    end else if (wr_same) begin
      valid <= 1'b1;
      dirty <= wr.dirty;
    end else begin
      valid <= valid_bits[rd_index];
      dirty <= dirty_bits[rd_index];
    end
  end

endmodule

`default_nettype wire

//--- design/req_stage.sv
`timescale 1ns/100ps
`default_nettype none

module req_stage #(
  parameter int INDEX_BITS = 8
) (
  input  wire                           clk,
  input  wire                           resetn,
  input  wire                           req_valid,
  input  wire dcache_pkg::cpu_req_t     req,
  input  wire dcache_pkg::cache_state_e state,
  input  wire                           hit,
  output logic                          addr_ok,
  output logic                          buf_valid,
  output dcache_pkg::cpu_req_t          buf_req,
  output logic [INDEX_BITS-1:0]         rd_index
);

  logic accept;

  // lookup with an empty buffer is ready too, hit is already gated by buf_valid
  always_comb begin
    unique case (state)
      dcache_pkg::IDLE:   addr_ok = 1'b1;
      dcache_pkg::LOOKUP: addr_ok = !buf_valid || (hit && buf_req.op == dcache_pkg::OP_LOAD);
      default:            addr_ok = 1'b0;
    endcase
  end

  assign accept = req_valid && addr_ok;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      buf_valid <= 1'b0;
    end else if (accept) begin
      buf_valid <= 1'b1;
    end else if (hit) begin
      buf_valid <= 1'b0;  // done, nothing queued behind it
    end
  end

  // held unchanged through a miss for the second lookup
  always_ff @(posedge clk) begin
    if (accept) begin
      buf_req <= req;
    end
  end

  // arrays read the new request on acceptance, else keep the buffered set
  assign rd_index = accept ? req.addr[dcache_pkg::OFFSET_BITS +: INDEX_BITS]
                           : buf_req.addr[dcache_pkg::OFFSET_BITS +: INDEX_BITS];

endmodule

`default_nettype wire

//--- design/hit_stage.sv
`timescale 1ns/100ps
`default_nettype none

module hit_stage #(
  parameter int INDEX_BITS = 8,
  localparam int TAG_BITS  = dcache_pkg::ADDR_W - INDEX_BITS - dcache_pkg::OFFSET_BITS
) (
  input  wire                           clk,
  input  wire                           resetn,
  input  wire dcache_pkg::cache_state_e state,
  input  wire                           buf_valid,
  input  wire dcache_pkg::cpu_req_t     buf_req,
  input  wire [TAG_BITS-1:0]            way0_tag,
  input  wire                           way0_valid,
  input  wire dcache_pkg::line_t        way0_line,
  input  wire [TAG_BITS-1:0]            way1_tag,
  input  wire                           way1_valid,
  input  wire dcache_pkg::line_t        way1_line,
  input  wire dcache_pkg::way_wr_t      refill_wr,
  input  wire                           refill_way,
  output logic                          hit,
  output logic                          victim_way,
  output logic                          data_ok,
  output dcache_pkg::word_t             rdata,
  output dcache_pkg::way_wr_t           way0_wr,
  output dcache_pkg::way_wr_t           way1_wr
);

  localparam int SETS      = 1 << INDEX_BITS;
  localparam int WSEL_BITS = $clog2(dcache_pkg::WORDS_PER_LINE);

  logic [TAG_BITS-1:0]   buf_tag;
  logic [INDEX_BITS-1:0] buf_index;
  logic [WSEL_BITS-1:0]  word_sel;
  logic                  hit0;
  logic                  hit1;
  dcache_pkg::line_t     hit_line;
  dcache_pkg::line_t     merged_line;
  logic [SETS-1:0]       lru;  // way to evict next, per set
  dcache_pkg::line_t     st_line;
  logic                  st_way;
  logic [INDEX_BITS-1:0] st_index;
  logic [TAG_BITS-1:0]   st_tag;
  dcache_pkg::way_wr_t   wr_sel;
  logic                  wr_way;

  assign buf_tag   = buf_req.addr[dcache_pkg::ADDR_W-1 -: TAG_BITS];
  assign buf_index = buf_req.addr[dcache_pkg::OFFSET_BITS +: INDEX_BITS];
  assign word_sel  = buf_req.addr[2 +: WSEL_BITS];

  assign hit0 = state == dcache_pkg::LOOKUP && buf_valid && way0_valid && way0_tag == buf_tag;
  assign hit1 = state == dcache_pkg::LOOKUP && buf_valid && way1_valid && way1_tag == buf_tag;
  assign hit  = hit0 || hit1;

  assign hit_line   = hit1 ? way1_line : way0_line;
  assign rdata      = hit_line[word_sel];
  assign data_ok    = hit;  // loads and stores both finish here
  assign victim_way = lru[buf_index];

  always_comb begin
    merged_line = hit_line;
    for (int b = 0; b < dcache_pkg::ADDR_W / 8; b++) begin
      if (buf_req.wstrb[b]) begin
        merged_line[word_sel][8*b +: 8] = buf_req.wdata[8*b +: 8];
      end
    end
  end

  // store hit, line goes back into the arrays next cycle
  always_ff @(posedge clk) begin
    if (hit && buf_req.op == dcache_pkg::OP_STORE) begin
      st_line  <= merged_line;
      st_way   <= hit1;
      st_index <= buf_index;
      st_tag   <= buf_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      lru <= '0;
    end else if (hit) begin
      lru[buf_index] <= !hit1;
    end else if (refill_wr.en) begin
      lru[refill_wr.index] <= !refill_way;
    end
  end

  always_comb begin
    if (state == dcache_pkg::STORE) begin
      wr_sel.en    = 1'b1;
      wr_sel.index = st_index;
      wr_sel.tag   = st_tag;
      wr_sel.line  = st_line;
      wr_sel.dirty = 1'b1;
      wr_way       = st_way;
    end else begin
      wr_sel = refill_wr;
      wr_way = refill_way;
    end
    way0_wr    = wr_sel;
    way0_wr.en = wr_sel.en && !wr_way;
    way1_wr    = wr_sel;
    way1_wr.en = wr_sel.en && wr_way;
  end

endmodule

`default_nettype wire

//--- design/miss_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module miss_fsm #(
  parameter int INDEX_BITS = 8,
  localparam int TAG_BITS  = dcache_pkg::ADDR_W - INDEX_BITS - dcache_pkg::OFFSET_BITS
) (
  input  wire                       clk,
  input  wire                       resetn,
  input  wire dcache_pkg::cpu_req_t buf_req,
  input  wire                       buf_valid,
  input  wire                       hit,
  input  wire                       victim_way,
  input  wire [TAG_BITS-1:0]        way0_tag,
  input  wire                       way0_dirty,
  input  wire dcache_pkg::line_t    way0_line,
  input  wire [TAG_BITS-1:0]        way1_tag,
  input  wire                       way1_dirty,
  input  wire dcache_pkg::line_t    way1_line,
  output dcache_pkg::mem_rd_t       mem_rd,
  input  wire                       mem_rd_rdy,
  input  wire                       ret_valid,
  input  wire dcache_pkg::line_t    ret_data,
  output dcache_pkg::mem_wr_t       mem_wr,
  input  wire                       mem_wr_rdy,
  output dcache_pkg::cache_state_e  state,
  output dcache_pkg::way_wr_t       refill_wr,
  output logic                      refill_way
);

  dcache_pkg::cache_state_e next_state;
  logic [TAG_BITS-1:0]      buf_tag;
  logic [INDEX_BITS-1:0]    buf_index;
  logic [TAG_BITS-1:0]      victim_tag;
  logic                     victim_dirty;
  dcache_pkg::line_t        victim_line;

  assign buf_tag   = buf_req.addr[dcache_pkg::ADDR_W-1 -: TAG_BITS];
  assign buf_index = buf_req.addr[dcache_pkg::OFFSET_BITS +: INDEX_BITS];

  // array outputs stay on the buffered set for the whole miss
  assign victim_tag   = victim_way ? way1_tag : way0_tag;
  assign victim_dirty = victim_way ? way1_dirty : way0_dirty;
  assign victim_line  = victim_way ? way1_line : way0_line;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= dcache_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      dcache_pkg::IDLE: next_state = dcache_pkg::LOOKUP;  // lookup also waits for requests
      dcache_pkg::LOOKUP: begin
        if (buf_valid && !hit) begin
          if (victim_dirty) begin
            next_state = dcache_pkg::MISS_DIRTY;
          end else begin
            next_state = dcache_pkg::MISS_CLEAN;
          end
        end else if (hit && buf_req.op == dcache_pkg::OP_STORE) begin
          next_state = dcache_pkg::STORE;
        end
      end
      dcache_pkg::STORE:      next_state = dcache_pkg::IDLE;
      dcache_pkg::MISS_DIRTY: if (mem_wr_rdy) next_state = dcache_pkg::MISS_CLEAN;
      dcache_pkg::MISS_CLEAN: if (mem_rd_rdy) next_state = dcache_pkg::REFILL;
      dcache_pkg::REFILL:     if (ret_valid) next_state = dcache_pkg::LOOKUP;  // look up again
      default:                next_state = dcache_pkg::IDLE;
    endcase
  end

  always_comb begin
    mem_wr.req  = state == dcache_pkg::MISS_DIRTY;
    mem_wr.addr = {victim_tag, buf_index, {dcache_pkg::OFFSET_BITS{1'b0}}};
    mem_wr.data = victim_line;

    mem_rd.req  = state == dcache_pkg::MISS_CLEAN;
    mem_rd.addr = {buf_tag, buf_index, {dcache_pkg::OFFSET_BITS{1'b0}}};

    refill_wr.en    = state == dcache_pkg::REFILL && ret_valid;
    refill_wr.index = buf_index;
    refill_wr.tag   = buf_tag;
    refill_wr.line  = ret_data;
    refill_wr.dirty = 1'b0;  // fresh from memory
  end

  assign refill_way = victim_way;

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
  parameter int INDEX_BITS = 8
) (
  input  wire                       clk,
  input  wire                       resetn,
  input  wire                       req_valid,
  input  wire dcache_pkg::cpu_req_t req,
  output logic                      addr_ok,
  output logic                      data_ok,
  output dcache_pkg::word_t         rdata,
  output dcache_pkg::mem_rd_t       mem_rd,
  input  wire                       mem_rd_rdy,
  input  wire                       ret_valid,
  input  wire dcache_pkg::line_t    ret_data,
  output dcache_pkg::mem_wr_t       mem_wr,
  input  wire                       mem_wr_rdy
);

  localparam int TAG_BITS = dcache_pkg::ADDR_W - INDEX_BITS - dcache_pkg::OFFSET_BITS;

  dcache_pkg::cache_state_e state;
  dcache_pkg::cpu_req_t     buf_req;
  logic                     buf_valid;
  logic [INDEX_BITS-1:0]    rd_index;
  logic                     hit;
  logic                     victim_way;
  logic                     refill_way;
  dcache_pkg::way_wr_t      refill_wr;
  dcache_pkg::way_wr_t      way0_wr;
  dcache_pkg::way_wr_t      way1_wr;
  logic [TAG_BITS-1:0]      way0_tag;
  logic [TAG_BITS-1:0]      way1_tag;
  logic                     way0_valid;
  logic                     way1_valid;
  logic                     way0_dirty;
  logic                     way1_dirty;
  dcache_pkg::line_t        way0_line;
  dcache_pkg::line_t        way1_line;

  req_stage #(.INDEX_BITS(INDEX_BITS)) u_req_stage (
    .clk, .resetn, .req_valid, .req, .state, .hit,
    .addr_ok, .buf_valid, .buf_req, .rd_index
  );

  way_store #(.INDEX_BITS(INDEX_BITS)) way0 (
    .clk, .resetn, .rd_index, .wr(way0_wr),
    .tag(way0_tag), .valid(way0_valid), .dirty(way0_dirty), .line(way0_line)
  );

  way_store #(.INDEX_BITS(INDEX_BITS)) way1 (
    .clk, .resetn, .rd_index, .wr(way1_wr),
    .tag(way1_tag), .valid(way1_valid), .dirty(way1_dirty), .line(way1_line)
  );

  hit_stage #(.INDEX_BITS(INDEX_BITS)) u_hit_stage (
    .clk, .resetn, .state, .buf_valid, .buf_req,
    .way0_tag, .way0_valid, .way0_line, .way1_tag, .way1_valid, .way1_line,
    .refill_wr, .refill_way, .hit, .victim_way, .data_ok, .rdata, .way0_wr, .way1_wr
  );

  miss_fsm #(.INDEX_BITS(INDEX_BITS)) u_miss_fsm (
    .clk, .resetn, .buf_req, .buf_valid, .hit, .victim_way,
    .way0_tag, .way0_dirty, .way0_line, .way1_tag, .way1_dirty, .way1_line,
    .mem_rd, .mem_rd_rdy, .ret_valid, .ret_data, .mem_wr, .mem_wr_rdy,
    .state, .refill_wr, .refill_way
  );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    resetn = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;  // released between edges
  end

endmodule

`default_nettype wire

//--- verif/dcache_assert.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_assert (
  input wire                      clk,
  input wire                      resetn,
  input wire                      req_valid,
  input wire                      addr_ok,
  input wire                      data_ok,
  input wire dcache_pkg::mem_rd_t mem_rd,
  input wire                      mem_rd_rdy,
  input wire dcache_pkg::mem_wr_t mem_wr,
  input wire                      mem_wr_rdy
);

  int fail_count = 0;

  rd_hold: assert property (@(posedge clk) disable iff (!resetn)
    mem_rd.req && !mem_rd_rdy |=> mem_rd.req && $stable(mem_rd.addr))
    else begin
      fail_count++;
      $error("line read request changed before mem_rd_rdy");
    end

  wr_hold: assert property (@(posedge clk) disable iff (!resetn)
    mem_wr.req && !mem_wr_rdy |=> mem_wr.req && $stable(mem_wr.addr) && $stable(mem_wr.data))
    else begin
      fail_count++;
      $error("line write request changed before mem_wr_rdy");
    end

  // a second pulse is only legal for a newly accepted request
  single_done: assert property (@(posedge clk) disable iff (!resetn)
    data_ok && !(req_valid && addr_ok) |=> !data_ok)
    else begin
      fail_count++;
      $error("data_ok held for two cycles on one request");
    end

  no_accept_on_read: assert property (@(posedge clk) disable iff (!resetn)
    mem_rd.req |-> !addr_ok)
    else begin
      fail_count++;
      $error("addr_ok high while a line read is pending");
    end

endmodule

bind dcache_top dcache_assert u_check (
  .clk(clk),
  .resetn(resetn),
  .req_valid(req_valid),
  .addr_ok(addr_ok),
  .data_ok(data_ok),
  .mem_rd(mem_rd),
  .mem_rd_rdy(mem_rd_rdy),
  .mem_wr(mem_wr),
  .mem_wr_rdy(mem_wr_rdy)
);

`default_nettype wire

//--- verif/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

  localparam int TIMEOUT  = 500;  // cycles per wait
  localparam int N_RANDOM = 200;

  logic                 clk;
  logic                 resetn;
  logic                 req_valid;
  dcache_pkg::cpu_req_t req;
  logic                 addr_ok;
  logic                 data_ok;
  dcache_pkg::word_t    rdata;
  dcache_pkg::mem_rd_t  mem_rd;
  logic                 mem_rd_rdy;
  logic                 ret_valid;
  dcache_pkg::line_t    ret_data;
  dcache_pkg::mem_wr_t  mem_wr;
  logic                 mem_wr_rdy;

  integer seed = 56;
  int     mismatches = 0;
  int     timeouts = 0;
  int     other_errors = 0;
  int     issued = 0;
  int     done_count = 0;
  int     rd_count = 0;
  int     wr_count = 0;
  logic [31:0] last_rd_addr = '0;
  logic [31:0] last_wr_addr = '0;

  dcache_pkg::word_t    mem_words [logic [31:0]];  // backing memory, touched words only
  dcache_pkg::word_t    shadow [logic [31:0]];     // processor view, stores applied at issue
  dcache_pkg::req_op_e  exp_op [$];
  dcache_pkg::word_t    exp_data [$];
  dcache_pkg::cpu_req_t rand_ops [N_RANDOM];

  tb_clock u_clock (.clk, .resetn);

  dcache_top UUT (
    .clk, .resetn, .req_valid, .req, .addr_ok, .data_ok, .rdata,
    .mem_rd, .mem_rd_rdy, .ret_valid, .ret_data, .mem_wr, .mem_wr_rdy
  );

  function automatic dcache_pkg::word_t fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  function automatic dcache_pkg::word_t mem_word(input logic [31:0] addr);
    return mem_words.exists(addr) ? mem_words[addr] : fill_word(addr);
  endfunction

  function automatic dcache_pkg::word_t expected_load(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {addr[31:2], 2'b00};
    return shadow.exists(wa) ? shadow[wa] : fill_word(wa);
  endfunction

  function automatic void shadow_store(input logic [31:0] addr, input logic [3:0] wstrb,
                                       input dcache_pkg::word_t wdata);
    dcache_pkg::word_t w;
    w = expected_load(addr);
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) w[8*b +: 8] = wdata[8*b +: 8];
    end
    shadow[{addr[31:2], 2'b00}] = w;
  endfunction

  function automatic dcache_pkg::line_t shadow_line(input logic [31:0] base);
    dcache_pkg::line_t l;
    for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
      l[w] = expected_load(base + 32'(4 * w));
    end
    return l;
  endfunction

  function automatic dcache_pkg::line_t memory_line(input logic [31:0] base);
    dcache_pkg::line_t l;
    for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
      l[w] = mem_word(base + 32'(4 * w));
    end
    return l;
  endfunction

  function automatic dcache_pkg::cpu_req_t make_req(input dcache_pkg::req_op_e op,
      input logic [31:0] addr, input logic [3:0] wstrb, input dcache_pkg::word_t wdata);
    return {op, addr, wstrb, wdata};
  endfunction

  task automatic check_word(input string name, input dcache_pkg::word_t got,
                            input dcache_pkg::word_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input dcache_pkg::line_t got,
                            input dcache_pkg::line_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic issue(input dcache_pkg::cpu_req_t r);
    int n;
    if (timeouts != 0) return;
    req_valid = 1'b1;
    req       = r;
    n         = 0;
    while (!addr_ok && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!addr_ok) begin
      timeouts++;
      $display("timeout at %0t: request to %h was never accepted", $time, r.addr);
    end else begin
      if (r.op == dcache_pkg::OP_STORE) begin
        shadow_store(r.addr, r.wstrb, r.wdata);
        exp_data.push_back('0);
      end else begin
        exp_data.push_back(expected_load(r.addr));
      end
      exp_op.push_back(r.op);
      issued++;
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done_count != issued && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (done_count != issued) begin
      timeouts++;
      $display("timeout at %0t: %0d requests never saw data_ok", $time, issued - done_count);
    end
  endtask

  // memory model, everything decided on the falling edge
  initial begin : memory_model
    logic        rd_busy;
    logic [31:0] rd_base;
    logic [1:0]  delay;
    logic [31:0] rnd;
    mem_rd_rdy = 1'b0;
    mem_wr_rdy = 1'b0;
    ret_valid  = 1'b0;
    ret_data   = '0;
    rd_busy    = 1'b0;
    rd_base    = '0;
    delay      = 2'd0;
    forever begin
      @(negedge clk);
      ret_valid = 1'b0;
      if (rd_busy) begin
        if (delay == 2'd0) begin
          ret_valid = 1'b1;
          ret_data  = memory_line(rd_base);
          rd_busy   = 1'b0;
        end else begin
          delay = delay - 2'd1;
        end
      end
      rnd        = $random(seed);
      mem_rd_rdy = rnd[1:0] != 2'b00;
      mem_wr_rdy = rnd[3:2] != 2'b00;
      if (mem_wr.req && mem_wr_rdy) begin  // taken on the next rising edge
        wr_count++;
        last_wr_addr = mem_wr.addr;
        check_line("mem_wr.data", mem_wr.data, shadow_line(mem_wr.addr));
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
          mem_words[mem_wr.addr + 32'(4 * w)] = mem_wr.data[w];
        end
      end
      if (mem_rd.req && mem_rd_rdy) begin
        rd_count++;
        last_rd_addr = mem_rd.addr;
        rd_busy      = 1'b1;
        rd_base      = mem_rd.addr;
        delay        = rnd[5:4];
      end
    end
  end

  always @(negedge clk) begin : compare_results
    dcache_pkg::req_op_e op;
    dcache_pkg::word_t   exp;
    if (resetn && data_ok) begin
      if (exp_op.size() == 0) begin
        other_errors++;
        $display("error at %0t: data_ok pulsed with no request outstanding", $time);
      end else begin
        op  = exp_op.pop_front();
        exp = exp_data.pop_front();
        if (op == dcache_pkg::OP_LOAD) check_word("rdata", rdata, exp);
        done_count++;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] a;
    int          rd0;
    int          wr0;
    int          n;
    int          fail_total;
    req_valid = 1'b0;
    req       = '0;
    // four sets, eight tags each
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd = $random(seed);
      rand_ops[i] = make_req(rnd[0] ? dcache_pkg::OP_STORE : dcache_pkg::OP_LOAD,
                             {15'h0001, rnd[3:1], 6'h2c, rnd[5:4], 2'b00, rnd[7:6], 2'b00},
                             rnd[11:8], $random(seed));
    end
    n = 0;
    while (!resetn && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!resetn) begin
      timeouts++;
      $display("timeout: reset was never released");
    end
    @(negedge clk);

    check_flag("addr_ok", addr_ok, 1'b1);
    check_flag("data_ok", data_ok, 1'b0);
    check_flag("mem_rd.req", mem_rd.req, 1'b0);
    check_flag("mem_wr.req", mem_wr.req, 1'b0);

    // cold load, one refill of the aligned line
    a   = 32'h0000_5a38;
    rd0 = rd_count;
    issue(make_req(dcache_pkg::OP_LOAD, a, 4'h0, '0));
    wait_done();
    check_flag("single line read", rd_count == rd0 + 1, 1'b1);
    check_word("mem_rd.addr", last_rd_addr, {a[31:4], 4'h0});

    rd0 = rd_count;
    wr0 = wr_count;
    issue(make_req(dcache_pkg::OP_LOAD, a, 4'h0, '0));
    check_flag("data_ok one cycle after accept", data_ok, 1'b1);
    wait_done();
    check_flag("no memory request on hit", rd_count == rd0 && wr_count == wr0, 1'b1);

    issue(make_req(dcache_pkg::OP_STORE, a, 4'b0110, 32'hdead_beef));
    issue(make_req(dcache_pkg::OP_LOAD, a, 4'h0, '0));
    wait_done();

    // three tags on set 0x34, the dirty first line gets evicted
    wr0 = wr_count;
    issue(make_req(dcache_pkg::OP_STORE, 32'h0001_2344, 4'hf, 32'h1357_9bdf));
    issue(make_req(dcache_pkg::OP_LOAD, 32'h0002_2340, 4'h0, '0));
    issue(make_req(dcache_pkg::OP_LOAD, 32'h0003_2348, 4'h0, '0));
    wait_done();
    check_flag("one write-back", wr_count == wr0 + 1, 1'b1);
    check_word("mem_wr.addr", last_wr_addr, 32'h0001_2340);
    issue(make_req(dcache_pkg::OP_LOAD, 32'h0001_2344, 4'h0, '0));
    wait_done();

    for (int i = 0; i < N_RANDOM; i++) begin
      issue(rand_ops[i]);
    end
    wait_done();

    fail_total = mismatches + timeouts + other_errors + UUT.u_check.fail_count;
    $display("%0d mismatches, %0d timeouts, %0d other errors, %0d assertion failures",
             mismatches, timeouts, other_errors, UUT.u_check.fail_count);
    if (fail_total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache_top.f
design/dcache_pkg.sv
design/way_store.sv
design/req_stage.sv
design/hit_stage.sv
design/miss_fsm.sv
design/dcache_top.sv
verif/tb_clock.sv
verif/dcache_assert.sv
verif/dcache_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
TOP       := dcache_tb
FILELIST  := dcache_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
